// ==== bench/countConnectedTb.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module countConnectedTb;
    localparam int cycleLimit = 200000;
    localparam int ackLimit = 100;
    localparam int randomJobs = 24;
    localparam int busyJobs = 12;

    logic clk;
    logic rst;
    countConnectedPkg::wbReq hostReq;
    countConnectedPkg::wbRsp hostRsp;
    logic start;
    logic [`CC_JOB_BITS-1:0] jobCount;
    logic busy;

    int wordErrors;
    int countErrors;
    int otherErrors;
    int cycleCount;
    logic [31:0] rngState;
    logic [`CC_GRAPH_BITS-1:0] graphs [randomJobs];

    countConnectedTop i_dut (
        .clk(clk),
        .rst(rst),
        .hostReq(hostReq),
        .hostRsp(hostRsp),
        .start(start),
        .jobCount(jobCount),
        .busy(busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped at the limit of %0d cycles", cycleLimit);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // two words ANDed leave about a quarter of the points set
    function automatic logic [`CC_GRAPH_BITS-1:0] randomGraph();
        logic [`CC_GRAPH_BITS-1:0] a;
        logic [`CC_GRAPH_BITS-1:0] b;
        for (int k = 0; k < 4; k++) begin
            a[32*k +: 32] = xorshift();
        end
        for (int k = 0; k < 4; k++) begin
            b[32*k +: 32] = xorshift();
        end
        return a & b;
    endfunction

    function automatic logic [`CC_GRAPH_BITS-1:0] fillPattern(input int adr);
        return {4{32'h9e3779b9 * (adr + 1)}} ^ `CC_GRAPH_BITS'(adr);
    endfunction

    // flood fill with an explicit stack
    function automatic int referenceCount(input logic [`CC_GRAPH_BITS-1:0] g);
        logic [`CC_GRAPH_BITS-1:0] left;
        int stack [$];
        int comps;
        int p;
        int n;
        left = g;
        comps = 0;
        for (int i = 0; i < `CC_GRAPH_BITS; i++) begin
            if (left[i]) begin
                comps++;
                left[i] = 1'b0;
                stack.push_back(i);
                while (stack.size() > 0) begin
                    p = stack.pop_back();
                    for (int d = 0; d < `CC_CUBE_DIM; d++) begin
                        n = p ^ (1 << d);
                        if (left[n]) begin
                            left[n] = 1'b0;
                            stack.push_back(n);
                        end
                    end
                end
            end
        end
        return comps;
    endfunction

    task automatic checkWord(input string testName, input logic [`CC_GRAPH_BITS-1:0] expected,
                             input countConnectedPkg::wbRsp actual);
        if (actual.dat !== expected) begin
            wordErrors++;
            $display("Error %s: expected %h, actual %h", testName, expected, actual.dat);
        end
    endtask

    task automatic checkCount(input string testName, input int expected,
                              input countConnectedPkg::wbRsp actual);
        if (actual.dat !== `CC_GRAPH_BITS'(expected)) begin
            countErrors++;
            $display("Error %s: expected %0d, actual %h", testName, expected, actual.dat);
        end
    endtask

    // one Wishbone classic transfer with cyc dropped the cycle after ack
    task automatic busTransfer(input logic we, input int adr,
                               input logic [`CC_GRAPH_BITS-1:0] dat,
                               output countConnectedPkg::wbRsp rsp);
        int waited;
        waited = 0;
        @(posedge clk);
        hostReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: `CC_ADDR_BITS'(adr), dat: dat};
        do begin
            @(negedge clk);
            waited++;
        end while (!hostRsp.ack && waited < ackLimit);
        rsp = hostRsp;
        if (!hostRsp.ack) begin
            otherErrors++;
            $display("host transfer to address %0d was never acknowledged", adr);
        end
        @(posedge clk);
        hostReq <= '0;
    endtask

    task automatic hostWrite(input int adr, input logic [`CC_GRAPH_BITS-1:0] dat);
        countConnectedPkg::wbRsp rsp;
        busTransfer(1'b1, adr, dat, rsp);
    endtask

    task automatic hostRead(input int adr, output countConnectedPkg::wbRsp rsp);
        busTransfer(1'b0, adr, '0, rsp);
    endtask

    task automatic startBatch(input int jobs);
        @(posedge clk);
        start <= 1'b1;
        jobCount <= `CC_JOB_BITS'(jobs);
        @(posedge clk);
        start <= 1'b0;
        jobCount <= '0;
    endtask

    task automatic waitIdle(input string testName, input int jobs);
        int waited;
        int limit;
        limit = jobs * 1000 + 200;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (busy && waited < limit);
        if (busy) begin
            otherErrors++;
            $display("%s: busy still high after %0d cycles", testName, limit);
        end
    endtask

    task automatic runBatch(input string testName, input int jobs);
        startBatch(jobs);
        waitIdle(testName, jobs);
    endtask

    task automatic testMemoryAccess();
        countConnectedPkg::wbRsp rsp;
        for (int a = 0; a < 8; a++) begin
            hostWrite(a, fillPattern(a));
            hostWrite(`CC_RESULT_BASE + a, fillPattern(`CC_RESULT_BASE + a));
        end
        for (int a = 0; a < 8; a++) begin
            hostRead(a, rsp);
            checkWord("memory graph area", fillPattern(a), rsp);
            hostRead(`CC_RESULT_BASE + a, rsp);
            checkWord("memory result area", fillPattern(`CC_RESULT_BASE + a), rsp);
        end
    endtask

    task automatic runSingle(input string testName, input logic [`CC_GRAPH_BITS-1:0] g,
                             input int expected);
        countConnectedPkg::wbRsp rsp;
        hostWrite(0, g);
        hostWrite(`CC_RESULT_BASE, '1);
        runBatch(testName, 1);
        hostRead(`CC_RESULT_BASE, rsp);
        checkCount(testName, expected, rsp);
    endtask

    task automatic testKnownGraphs();
        logic [`CC_GRAPH_BITS-1:0] even;
        for (int i = 0; i < `CC_GRAPH_BITS; i++) begin
            even[i] = ($countones(i) % 2 == 0);
        end
        runSingle("known empty", '0, 0);
        runSingle("known full", '1, 1);
        runSingle("known corners", (`CC_GRAPH_BITS'(1) << 127) | `CC_GRAPH_BITS'(1), 2);
        runSingle("known even parity", even, 64);
        runSingle("known path", `CC_GRAPH_BITS'(11), 1);
    endtask

    task automatic loadRandom(input int jobs);
        for (int j = 0; j < jobs; j++) begin
            graphs[j] = randomGraph();
            hostWrite(j, graphs[j]);
            hostWrite(`CC_RESULT_BASE + j, '1);
        end
    endtask

    task automatic checkResults(input string testName, input int jobs);
        countConnectedPkg::wbRsp rsp;
        for (int j = 0; j < jobs; j++) begin
            hostRead(`CC_RESULT_BASE + j, rsp);
            checkCount(testName, referenceCount(graphs[j]), rsp);
        end
    endtask

    task automatic testRandomBatch();
        loadRandom(randomJobs);
        runBatch("random batch", randomJobs);
        checkResults("random batch", randomJobs);
    endtask

    task automatic testZeroBatch();
        logic sawBusy;
        sawBusy = 1'b0;
        startBatch(0);
        repeat (20) begin
            @(negedge clk);
            if (busy) sawBusy = 1'b1;
        end
        if (sawBusy) begin
            otherErrors++;
            $display("zero batch: busy went high for a batch of no jobs");
        end
        checkResults("zero batch", randomJobs);
    endtask

    // host competes with the cores for the memory
    task automatic testReadsDuringBatch();
        countConnectedPkg::wbRsp rsp;
        int overlapped;
        overlapped = 0;
        loadRandom(busyJobs);
        startBatch(busyJobs);
        for (int j = 0; j < busyJobs; j++) begin
            @(negedge clk);
            if (busy) overlapped++;
            hostRead(j, rsp);
            checkWord("reads during batch", graphs[j], rsp);
        end
        if (overlapped == 0) begin
            otherErrors++;
            $display("reads during batch: the batch ended before any host read");
        end
        waitIdle("reads during batch", busyJobs);
        checkResults("reads during batch", busyJobs);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        jobCount = '0;
        hostReq = '0;
        wordErrors = 0;
        countErrors = 0;
        otherErrors = 0;
        rngState = 32'h906a27b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        testMemoryAccess();
        testKnownGraphs();
        testRandomBatch();
        testZeroBatch();
        testReadsDuringBatch();
        $display("errors: word %0d, count %0d, other %0d", wordErrors, countErrors, otherErrors);
        if (wordErrors + countErrors + otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+logic
logic/countConnectedPkg.sv
logic/firstBitFinder.sv
logic/componentExplorer.sv
logic/countConnectedCore.sv
logic/graphMemory.sv
logic/busArbiter.sv
logic/jobDispatcher.sv
logic/countConnectedTop.sv
bench/countConnectedTb.sv

// ==== logic/busArbiter.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module busArbiter #(
    parameter int numCores = `CC_NUM_CORES
) (
    input  logic clk,
    input  logic rst,
    input  countConnectedPkg::wbReq masterReq [numCores+1],
    output countConnectedPkg::wbRsp masterRsp [numCores+1],
    output countConnectedPkg::wbReq slaveReq,
    input  countConnectedPkg::wbRsp slaveRsp
);
    localparam int numMasters = numCores + 1;
    localparam int idxBits = $clog2(numMasters);

    logic [idxBits-1:0] owner;
    logic ownerValid;
    logic [idxBits-1:0] pick;
    logic pickValid;
    logic [numMasters-1:0] ackVec;

    // search starts one past the last owner, which is tried last
    always_comb begin : nextOwner
        int cand;
        pick = owner;
        pickValid = 1'b0;
        for (int k = numMasters; k >= 1; k--) begin
            cand = (int'(owner) + k) % numMasters;
            if (masterReq[cand].cyc) begin
                pick = idxBits'(cand);
                pickValid = 1'b1;
            end
        end
    end

    // grant lasts as long as the owner's cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= '0;
            ownerValid <= 1'b0;
        end else if (ownerValid) begin
            if (!masterReq[owner].cyc) begin
                ownerValid <= 1'b0;
            end
        end else if (pickValid) begin
            owner <= pick;
            ownerValid <= 1'b1;
        end
    end

    assign slaveReq = ownerValid ? masterReq[owner] : countConnectedPkg::wbReq'('0);

    // read data fans out, ack only to the owner
    for (genvar i = 0; i < numMasters; i++) begin : rspRoute
        assign ackVec[i] = slaveRsp.ack && ownerValid && (owner == idxBits'(i));
        assign masterRsp[i] = '{ack: ackVec[i], dat: slaveRsp.dat};
    end

    // memory ack lands on exactly one master, granted since the request
    ackToOwner: assert property (@(posedge clk) disable iff (rst)
        slaveRsp.ack |-> $onehot(ackVec) && $past(ownerValid) && $stable(owner));

endmodule

// ==== logic/componentExplorer.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module componentExplorer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [`CC_GRAPH_BITS-1:0] graph,
    output logic done,
    output logic [`CC_COUNT_BITS-1:0] count
);
    countConnectedPkg::explorerState state;
    logic [`CC_GRAPH_BITS-1:0] leftover;
    logic [`CC_GRAPH_BITS-1:0] leftoverNext;
    logic [`CC_GRAPH_BITS-1:0] cur;
    logic [`CC_GRAPH_BITS-1:0] grown;
    logic [`CC_GRAPH_BITS-1:0] curNext;
    logic [`CC_GRAPH_BITS-1:0] seed;
    logic seedReady;

    // finder watches the next leftover, so its first stage overlaps the load
    firstBitFinder i_finder (
        .clk(clk),
        .graph(leftoverNext),
        .seed(seed)
    );

    always_comb begin
        leftoverNext = leftover;
        if (state == countConnectedPkg::explIdle && start) begin
            leftoverNext = graph;
        end else if (state == countConnectedPkg::explRemove) begin
            leftoverNext = leftover & ~cur;
        end
    end

    // one step: every point plus its neighbours across each of the 7 axes
    always_comb begin
        grown = cur;
        for (int d = 0; d < `CC_CUBE_DIM; d++) begin
            for (int i = 0; i < `CC_GRAPH_BITS; i++) begin
                grown[i] = grown[i] | cur[i ^ (1 << d)];
            end
        end
    end

    assign curNext = leftover & grown;

    always_ff @(posedge clk) begin
        leftover <= leftoverNext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= countConnectedPkg::explIdle;
            done <= 1'b0;
            seedReady <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                countConnectedPkg::explIdle: begin
                    if (start) begin
                        count <= '0;
                        seedReady <= 1'b0;
                        state <= countConnectedPkg::explSeed;
                    end
                end
                countConnectedPkg::explSeed: begin
                    if (leftover == '0) begin
                        done <= 1'b1;
                        state <= countConnectedPkg::explIdle;
                    end else if (!seedReady) begin
                        seedReady <= 1'b1;
                    end else begin
                        cur <= seed;
                        state <= countConnectedPkg::explExpand;
                    end
                end
                countConnectedPkg::explExpand: begin
                    // fixed point reached, the component is complete
                    if (curNext == cur) begin
                        state <= countConnectedPkg::explRemove;
                    end else begin
                        cur <= curNext;
                    end
                end
                countConnectedPkg::explRemove: begin
                    count <= count + 1'b1;
                    seedReady <= 1'b0;
                    state <= countConnectedPkg::explSeed;
                end
                default: state <= countConnectedPkg::explIdle;
            endcase
        end
    end

    // growth never escapes the remaining points
    curInLeftover: assert property (@(posedge clk) disable iff (rst)
        state == countConnectedPkg::explExpand |-> (cur & ~leftover) == '0);

endmodule

// ==== logic/countConnectedCore.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module countConnectedCore (
    input  logic clk,
    input  logic rst,
    output countConnectedPkg::wbReq bus,
    input  countConnectedPkg::wbRsp busRsp,
    output logic jobReq,
    input  countConnectedPkg::jobAssign job,
    output logic jobDone
);
    countConnectedPkg::coreState state;
    logic [`CC_JOB_BITS-1:0] jobIndex;
    logic explStart;
    logic explDone;
    logic [`CC_COUNT_BITS-1:0] explCount;

    assign jobReq = (state == countConnectedPkg::coreClaim);

    // graph word goes straight from the bus into the explorer on the read ack
    assign explStart = (state == countConnectedPkg::coreFetch) && busRsp.ack;

    componentExplorer i_explorer (
        .clk(clk),
        .rst(rst),
        .start(explStart),
        .graph(busRsp.dat),
        .done(explDone),
        .count(explCount)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= countConnectedPkg::coreIdle;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            jobDone <= 1'b0;
        end else begin
            jobDone <= 1'b0;
            case (state)
                countConnectedPkg::coreIdle: begin
                    state <= countConnectedPkg::coreClaim;
                end
                countConnectedPkg::coreClaim: begin
                    if (job.valid) begin
                        jobIndex <= job.index;
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        bus.we <= 1'b0;
                        bus.adr <= `CC_ADDR_BITS'(job.index);
                        state <= countConnectedPkg::coreFetch;
                    end
                end
                countConnectedPkg::coreFetch: begin
                    if (busRsp.ack) begin
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        state <= countConnectedPkg::coreCount;
                    end
                end
                countConnectedPkg::coreCount: begin
                    // result word is the zero-extended count
                    if (explDone) begin
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        bus.we <= 1'b1;
                        bus.adr <= `CC_ADDR_BITS'(`CC_RESULT_BASE + jobIndex);
                        bus.dat <= `CC_GRAPH_BITS'(explCount);
                        state <= countConnectedPkg::coreStore;
                    end
                end
                countConnectedPkg::coreStore: begin
                    if (busRsp.ack) begin
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        jobDone <= 1'b1;
                        state <= countConnectedPkg::coreIdle;
                    end
                end
                default: state <= countConnectedPkg::coreIdle;
            endcase
        end
    end

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst)
        $rose(bus.stb) |-> bus.cyc);

    // the arbiter routes ack only to the core whose transfer is pending
    ackOnlyWhenPending: assert property (@(posedge clk) disable iff (rst)
        busRsp.ack |-> bus.cyc && bus.stb);

endmodule

// ==== logic/countConnectedPkg.sv ====
`include "countConnected_consts.svh"

package countConnectedPkg;

    // master side of a Wishbone classic transfer
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [`CC_ADDR_BITS-1:0] adr;
        logic [`CC_GRAPH_BITS-1:0] dat;
    } wbReq;

    // slave side
    typedef struct packed {
        logic ack;
        logic [`CC_GRAPH_BITS-1:0] dat;
    } wbRsp;

    typedef struct packed {
        logic valid;
        logic [`CC_JOB_BITS-1:0] index;
    } jobAssign;

    typedef enum logic [2:0] {
        coreIdle,
        coreClaim,
        coreFetch,
        coreCount,
        coreStore
    } coreState;

    typedef enum logic [1:0] {
        explIdle,
        explSeed,
        explExpand,
        explRemove
    } explorerState;

endpackage

// ==== logic/countConnectedTop.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module countConnectedTop #(
    parameter int numCores = `CC_NUM_CORES
) (
    input  logic clk,
    input  logic rst,
    input  countConnectedPkg::wbReq hostReq,
    output countConnectedPkg::wbRsp hostRsp,
    input  logic start,
    input  logic [`CC_JOB_BITS-1:0] jobCount,
    output logic busy
);
    // master 0 is the host, cores follow
    countConnectedPkg::wbReq masterReq [numCores+1];
    countConnectedPkg::wbRsp masterRsp [numCores+1];
    countConnectedPkg::wbReq memReq;
    countConnectedPkg::wbRsp memRsp;
    countConnectedPkg::jobAssign job [numCores];
    logic [numCores-1:0] jobReq;
    logic [numCores-1:0] jobDone;

    assign masterReq[0] = hostReq;
    assign hostRsp = masterRsp[0];

    jobDispatcher #(.numCores(numCores)) i_dispatcher (
        .clk(clk),
        .rst(rst),
        .start(start),
        .jobCount(jobCount),
        .jobReq(jobReq),
        .jobDone(jobDone),
        .job(job),
        .busy(busy)
    );

    for (genvar i = 0; i < numCores; i++) begin : coreGen
        countConnectedCore i_core (
            .clk(clk),
            .rst(rst),
            .bus(masterReq[i+1]),
            .busRsp(masterRsp[i+1]),
            .jobReq(jobReq[i]),
            .job(job[i]),
            .jobDone(jobDone[i])
        );
    end

    busArbiter #(.numCores(numCores)) i_arbiter (
        .clk(clk),
        .rst(rst),
        .masterReq(masterReq),
        .masterRsp(masterRsp),
        .slaveReq(memReq),
        .slaveRsp(memRsp)
    );

    graphMemory i_memory (
        .clk(clk),
        .rst(rst),
        .req(memReq),
        .rsp(memRsp)
    );

endmodule

// ==== logic/countConnected_consts.svh ====
`ifndef COUNT_CONNECTED_CONSTS_SVH
`define COUNT_CONNECTED_CONSTS_SVH

// one truth table per word, also the bus data width
`define CC_GRAPH_BITS 128
`define CC_CUBE_DIM 7

// word address map: graphs from 0, results from CC_RESULT_BASE
`define CC_ADDR_BITS 8
`define CC_RESULT_BASE 128

// at most 64 components in a 7-cube
`define CC_COUNT_BITS 7
`define CC_JOB_BITS 8

`define CC_NUM_CORES 3

`endif

// ==== logic/firstBitFinder.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module firstBitFinder (
    input  logic clk,
    input  logic [`CC_GRAPH_BITS-1:0] graph,
    output logic [`CC_GRAPH_BITS-1:0] seed
);
    localparam int groups4 = `CC_GRAPH_BITS / 4;
    localparam int groups16 = `CC_GRAPH_BITS / 16;
    localparam int sel16Bits = $clog2(groups16);

    logic [`CC_GRAPH_BITS-1:0] graphHeld;
    logic [groups4-1:0] has4;
    logic [groups16-1:0] has16;
    logic [sel16Bits-1:0] sel16;
    logic [1:0] sel4;
    logic [1:0] selBit;
    logic [3:0] nibble;

    // stage 1: occupancy of every 4-bit and 16-bit group
    always_ff @(posedge clk) begin
        graphHeld <= graph;
        for (int i = 0; i < groups4; i++) begin
            has4[i] <= |graph[4*i +: 4];
        end
        for (int i = 0; i < groups16; i++) begin
            has16[i] <= |graph[16*i +: 16];
        end
    end

    // walk down from high index so the lowest hit is the last one written
    always_comb begin
        sel16 = '0;
        for (int g = groups16 - 1; g >= 0; g--) begin
            if (has16[g]) sel16 = sel16Bits'(g);
        end
        sel4 = '0;
        for (int k = 3; k >= 0; k--) begin
            if (has4[{sel16, 2'(k)}]) sel4 = 2'(k);
        end
        nibble = graphHeld[{sel16, sel4, 2'b00} +: 4];
        selBit = '0;
        for (int b = 3; b >= 0; b--) begin
            if (nibble[b]) selBit = 2'(b);
        end
    end

    // stage 2: one-hot seed, zero for an empty graph
    always_ff @(posedge clk) begin
        seed <= (|has16) ? (`CC_GRAPH_BITS'(1) << {sel16, sel4, selBit}) : '0;
    end

endmodule

// ==== logic/graphMemory.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module graphMemory (
    input  logic clk,
    input  logic rst,
    input  countConnectedPkg::wbReq req,
    output countConnectedPkg::wbRsp rsp
);
    localparam int depth = 1 << `CC_ADDR_BITS;

    logic [`CC_GRAPH_BITS-1:0] mem [depth];
    logic [`CC_GRAPH_BITS-1:0] readData;
    logic ackReg;
    logic access;

    // stb is still high in the ack cycle and must not start a second access
    assign access = req.cyc && req.stb && !ackReg;

    // read returns the old word when the same transfer writes
    always_ff @(posedge clk) begin
        if (access) begin
            readData <= mem[req.adr];
            if (req.we) begin
                mem[req.adr] <= req.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= access;
        end
    end

    assign rsp.ack = ackReg;
    assign rsp.dat = readData;

    // ack answers a transfer that the master still holds unchanged
    ackFollowsStb: assert property (@(posedge clk) disable iff (rst)
        rsp.ack |-> $past(req.cyc && req.stb) && req.cyc && req.stb
            && $stable(req.adr) && $stable(req.we));

endmodule

// ==== logic/jobDispatcher.sv ====
`timescale 1ns/1ps
`include "countConnected_consts.svh"

module jobDispatcher #(
    parameter int numCores = `CC_NUM_CORES
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [`CC_JOB_BITS-1:0] jobCount,
    input  logic [numCores-1:0] jobReq,
    input  logic [numCores-1:0] jobDone,
    output countConnectedPkg::jobAssign job [numCores],
    output logic busy
);
    logic [`CC_JOB_BITS-1:0] total;
    logic [`CC_JOB_BITS-1:0] issued;
    logic [`CC_JOB_BITS-1:0] finished;
    logic canIssue;
    logic [numCores-1:0] grant;

    assign canIssue = busy && (issued < total);

    // lowest requesting core wins
    assign grant = canIssue ? (jobReq & (~jobReq + 1'b1)) : '0;

    for (genvar i = 0; i < numCores; i++) begin : assignOut
        assign job[i] = '{valid: grant[i], index: issued};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            total <= '0;
            issued <= '0;
            finished <= '0;
            busy <= 1'b0;
        end else if (start) begin
            total <= jobCount;
            issued <= '0;
            finished <= '0;
            busy <= (jobCount != '0);
        end else begin
            if (|grant) begin
                issued <= issued + 1'b1;
            end
            // several cores may finish in the same cycle
            finished <= finished + `CC_JOB_BITS'($countones(jobDone));
            if (busy && finished == total) begin
                busy <= 1'b0;
            end
        end
    end

    // a core only reports jobs it was handed
    doneAfterIssue: assert property (@(posedge clk) disable iff (rst)
        finished <= issued);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator; the exit status follows the testbench verdict
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f files.f --top-module countConnectedTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
